// File: verilog/fl_pkg.sv
package fl_pkg;

	// --------------------------------------
	// Number format
	// --------------------------------------

	localparam int NBMANT = 16;                      // Mantissa bits, no hidden bit
	localparam int NBEXPO = 6;                       // Exponent bits, two's complement
	localparam int NBPROD = 2 * NBMANT;              // Full mantissa product
	localparam int NBSHFT = $clog2(NBMANT + 1);      // Product shift count, 0 to NBMANT
	localparam int NBWIDE = NBMANT + 2**NBEXPO - 1;  // Mantissa shifted over the widest gap

	typedef logic        [NBMANT-1:0] fl_mant_t;
	typedef logic signed [NBEXPO-1:0] fl_expo_t;
	typedef logic        [NBPROD-1:0] fl_prod_t;
	typedef logic        [NBSHFT-1:0] fl_shift_t;
	typedef logic        [NBWIDE-1:0] fl_wide_t;

	// Data word of memory, ports and accumulator
	typedef struct packed {
		logic     sign;  // Set means negative
		fl_expo_t expo;
		fl_mant_t mant;
	} fl_word_t;

	// Arithmetic constants
	localparam fl_word_t FL_ZERO = '0;  // Only zero form produced
	localparam fl_word_t FL_ONE  = '{sign: 1'b0, expo: '0, mant: fl_mant_t'(1)};

endpackage

// File: verilog/isa_pkg.sv
package isa_pkg;

	// Memory and I/O sizes
	localparam int MDATAS = 64;                // Data words
	localparam int MINSTS = 64;                // Instruction words
	localparam int NUIOIN = 2;                 // Input ports
	localparam int NUIOOU = 2;                 // Output ports
	localparam int NBOPCO = 6;                 // Opcode bits
	localparam int NBOPER = $clog2(MDATAS);    // Operand bits

	typedef logic [NBOPER-1:0] operand_t;  // Data address, port or jump target

	// --------------------------------------
	// Instruction word
	// --------------------------------------

	typedef enum logic [NBOPCO-1:0] {
		OP_NOP = 6'd0,
		OP_LOD = 6'd1,   // acc = mem
		OP_STO = 6'd2,   // mem = acc
		OP_IN  = 6'd3,   // acc = port
		OP_OUT = 6'd4,   // port = acc
		OP_ADD = 6'd5,
		OP_MLT = 6'd6,
		OP_NEG = 6'd7,
		OP_ABS = 6'd8,
		OP_GRE = 6'd9,   // acc = (acc > mem)
		OP_EQU = 6'd10,  // acc = (acc == mem)
		OP_JMP = 6'd11,
		OP_JIZ = 6'd12   // Jump if acc is zero
	} opcode_t;

	typedef struct packed {
		opcode_t  opcode;
		operand_t operand;
	} instr_t;  // ROM word, opcode on top

	// --------------------------------------
	// Decoded control
	// --------------------------------------

	typedef enum logic [2:0] {
		ALU_PASS, ALU_ADD, ALU_MLT, ALU_NEG, ALU_ABS, ALU_GRE, ALU_EQU
	} alu_op_t;

	typedef struct packed {
		alu_op_t  alu_op;
		logic     acc_we;   // Accumulator write
		logic     mem_we;   // Data memory write
		logic     use_in;   // Accumulator from input port
		logic     out_en;   // Output port write
		logic     jump;
		logic     jump_z;
		operand_t operand;
	} ctrl_t;

	localparam ctrl_t CTRL_NOP = '0;

	typedef enum logic [1:0] {ST_FETCH, ST_DECODE, ST_EXEC} core_state_t;

endpackage

// File: verilog/mem_instr.sv
`timescale 1ns/1ps

module mem_instr import isa_pkg::*; (
	input  logic     clk,
	input  operand_t instr_addr,
	output instr_t   instr
);

	instr_t rom [MINSTS];  // Program store

	// Program image
	initial begin
		$readmemh("verilog/inst.hex", rom);
	end

	// Registered read with the word valid one cycle after the address
	always_ff @(posedge clk) begin
		instr <= rom[instr_addr];
	end

endmodule

// File: verilog/mem_data.sv
`timescale 1ns/1ps

module mem_data import fl_pkg::*, isa_pkg::*; (
	input  logic     clk,
	input  logic     mem_wr,
	input  operand_t mem_addr_w,
	input  operand_t mem_addr_r,
	input  fl_word_t mem_wdata,
	output fl_word_t mem_rdata
);

	fl_word_t ram [MDATAS];  // Variables

	// Write port
	always_ff @(posedge clk) begin
		if (mem_wr)
			ram[mem_addr_w] <= mem_wdata;
	end

	// Read port, one cycle latency
	always_ff @(posedge clk) begin
		mem_rdata <= ram[mem_addr_r];
	end

endmodule

// File: verilog/decode_fl.sv
`timescale 1ns/1ps

module decode_fl import isa_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   load,    // High in DECODE
	input  instr_t instr,
	output ctrl_t  ctrl
);

	ctrl_t dec;  // Control for the present word

	// Opcode to control fields
	always_comb begin
		dec         = CTRL_NOP;
		dec.operand = instr.operand;
		case (instr.opcode)
			OP_LOD: dec.acc_we = 1'b1;  // ALU passes memory data
			OP_STO: dec.mem_we = 1'b1;
			OP_IN: begin
				dec.use_in = 1'b1;
				dec.acc_we = 1'b1;
			end
			OP_OUT: dec.out_en = 1'b1;
			OP_ADD: begin
				dec.alu_op = ALU_ADD;
				dec.acc_we = 1'b1;
			end
			OP_MLT: begin
				dec.alu_op = ALU_MLT;
				dec.acc_we = 1'b1;
			end
			OP_NEG: begin
				dec.alu_op = ALU_NEG;
				dec.acc_we = 1'b1;
			end
			OP_ABS: begin
				dec.alu_op = ALU_ABS;
				dec.acc_we = 1'b1;
			end
			OP_GRE: begin
				dec.alu_op = ALU_GRE;
				dec.acc_we = 1'b1;
			end
			OP_EQU: begin
				dec.alu_op = ALU_EQU;
				dec.acc_we = 1'b1;
			end
			OP_JMP: dec.jump   = 1'b1;
			OP_JIZ: dec.jump_z = 1'b1;
			default: dec = CTRL_NOP;  // NOP and unknown codes
		endcase
	end

	// Control register, held through EXEC
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ctrl <= CTRL_NOP;
		else if (load)
			ctrl <= dec;
	end

endmodule

// File: verilog/execute_fl.sv
`timescale 1ns/1ps

module execute_fl import fl_pkg::*, isa_pkg::*; (
	input  alu_op_t  alu_op,
	input  fl_word_t acc,
	input  fl_word_t opnd,   // Memory data
	output fl_word_t res
);

	logic     [NBEXPO:0] e_diff;        // acc.expo - opnd.expo, one extra bit
	logic     [NBEXPO:0] shamt;         // Exponent gap, 0 to 63
	logic                a_big;         // acc has the larger exponent
	fl_mant_t            m_big, m_sml;  // m_sml already aligned
	logic                s_big, s_sml;
	fl_expo_t            e_big;
	logic     [NBMANT:0] add_sum;       // Room for the carry
	logic                add_sign;
	fl_word_t            add_res;
	fl_prod_t            prod;
	fl_shift_t           mlt_sh;
	fl_word_t            mlt_res;
	fl_wide_t            wide_a, wide_b;
	logic                sa, sb;        // Signs of nonzero values
	logic                cmp_gt, cmp_eq;
	fl_word_t            alu_raw;

	// --------------------------------------
	// Exponent alignment
	// --------------------------------------

	assign e_diff = {acc.expo[NBEXPO-1], acc.expo} - {opnd.expo[NBEXPO-1], opnd.expo};
	assign a_big  = ~e_diff[NBEXPO];
	assign shamt  = a_big ? e_diff : -e_diff;

	assign m_big = a_big ? acc.mant  : opnd.mant;
	assign m_sml = (a_big ? opnd.mant : acc.mant) >> shamt;  // Truncating shift
	assign s_big = a_big ? acc.sign  : opnd.sign;
	assign s_sml = a_big ? opnd.sign : acc.sign;
	assign e_big = a_big ? acc.expo  : opnd.expo;

	// Add or subtract magnitudes, sign of the larger one
	always_comb begin
		if (s_big == s_sml) begin
			add_sum  = {1'b0, m_big} + {1'b0, m_sml};
			add_sign = s_big;
		end else if (m_big >= m_sml) begin
			add_sum  = {1'b0, m_big} - {1'b0, m_sml};
			add_sign = s_big;
		end else begin
			add_sum  = {1'b0, m_sml} - {1'b0, m_big};
			add_sign = s_sml;
		end
		add_res.sign = add_sign;
		if (add_sum[NBMANT]) begin  // Carry out, renormalize
			add_res.expo = e_big + fl_expo_t'(1);
			add_res.mant = add_sum[NBMANT:1];
		end else begin
			add_res.expo = e_big;
			add_res.mant = add_sum[NBMANT-1:0];
		end
	end

	// Multiply, drop low bits until the product fits the mantissa
	always_comb begin
		prod   = acc.mant * opnd.mant;
		mlt_sh = '0;
		for (int i = NBMANT; i < NBPROD; i++)
			if (prod[i])
				mlt_sh = fl_shift_t'(i - NBMANT + 1);  // Highest set bit wins
		mlt_res.sign = acc.sign ^ opnd.sign;
		mlt_res.expo = acc.expo + opnd.expo + fl_expo_t'(mlt_sh);
		mlt_res.mant = fl_mant_t'(prod >> mlt_sh);
	end

	// --------------------------------------
	// Exact compare on represented values
	// --------------------------------------

	assign wide_a = fl_wide_t'(acc.mant)  << (a_big ? shamt : '0);
	assign wide_b = fl_wide_t'(opnd.mant) << (a_big ? '0 : shamt);
	assign sa     = acc.sign  & (|acc.mant);   // Negative zero counts as zero
	assign sb     = opnd.sign & (|opnd.mant);
	assign cmp_eq = (sa == sb) && (wide_a == wide_b);

	always_comb begin
		case ({sa, sb})
			2'b00:   cmp_gt = wide_a > wide_b;
			2'b01:   cmp_gt = 1'b1;            // Positive over negative
			2'b10:   cmp_gt = 1'b0;
			default: cmp_gt = wide_a < wide_b; // Both negative
		endcase
	end

	// Result select and zero cleanup
	always_comb begin
		alu_raw = opnd;  // PASS for LOD
		case (alu_op)
			ALU_ADD: alu_raw = add_res;
			ALU_MLT: alu_raw = mlt_res;
			ALU_NEG: alu_raw = '{sign: ~acc.sign, expo: acc.expo, mant: acc.mant};
			ALU_ABS: alu_raw = '{sign: 1'b0, expo: acc.expo, mant: acc.mant};
			ALU_GRE: alu_raw = cmp_gt ? FL_ONE : FL_ZERO;
			ALU_EQU: alu_raw = cmp_eq ? FL_ONE : FL_ZERO;
			default: alu_raw = opnd;
		endcase
		res = (alu_raw.mant == '0) ? FL_ZERO : alu_raw;
	end

endmodule

// File: verilog/result_fl.sv
`timescale 1ns/1ps

module result_fl import fl_pkg::*, isa_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     commit,     // High in EXEC
	input  ctrl_t    ctrl,
	input  fl_word_t alu_res,
	input  fl_word_t io_in,
	input  operand_t pc,
	output fl_word_t acc,
	output operand_t pc_next,
	output logic     mem_wr,
	output operand_t mem_addr_w,
	output fl_word_t io_out,
	output logic     addr_out,
	output logic     out_en
);

	// --------------------------------------
	// Next program counter
	// --------------------------------------

	always_comb begin
		if (ctrl.jump || (ctrl.jump_z && acc == FL_ZERO))
			pc_next = ctrl.operand;           // Branch taken
		else
			pc_next = pc + operand_t'(1);     // Wraps at the ROM end
	end

	// Accumulator and strobes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc    <= FL_ZERO;
			mem_wr <= 1'b0;
			out_en <= 1'b0;
		end else begin
			mem_wr <= commit & ctrl.mem_we;   // Write lands in the next FETCH
			out_en <= commit & ctrl.out_en;   // One cycle pulse
			if (commit && ctrl.acc_we)
				acc <= ctrl.use_in ? io_in : alu_res;
		end
	end

	// Write address and output port data
	always_ff @(posedge clk) begin
		if (commit && ctrl.mem_we)
			mem_addr_w <= ctrl.operand;
		if (commit && ctrl.out_en) begin
			io_out   <= acc;
			addr_out <= ctrl.operand[$clog2(NUIOOU)-1:0];
		end
	end

endmodule

// File: verilog/core_fl.sv
`timescale 1ns/1ps

module core_fl import fl_pkg::*, isa_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  instr_t   instr,
	output operand_t instr_addr,
	output logic     mem_wr,
	output operand_t mem_addr_w,
	output operand_t mem_addr_r,
	output fl_word_t mem_wdata,
	input  fl_word_t mem_rdata,
	input  fl_word_t io_in,
	output logic     addr_in,
	output logic     req_in,
	output fl_word_t io_out,
	output logic     addr_out,
	output logic     out_en
);

	core_state_t state;
	operand_t    pc, pc_next;
	ctrl_t       ctrl;        // Registered in DECODE
	fl_word_t    acc, alu_res;
	logic        load, commit;

	assign load   = (state == ST_DECODE);
	assign commit = (state == ST_EXEC);

	// --------------------------------------
	// Sequencer, three cycles per instruction
	// --------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_FETCH;
			pc    <= '0;
		end else begin
			case (state)
				ST_FETCH:  state <= ST_DECODE;
				ST_DECODE: state <= ST_EXEC;
				default:   state <= ST_FETCH;
			endcase
			if (commit)
				pc <= pc_next;
		end
	end

	assign instr_addr = pc;                  // FETCH
	assign mem_addr_r = instr.operand;       // DECODE, data ready in EXEC
	assign mem_wdata  = acc;                 // STO leaves acc untouched
	assign req_in     = commit & ctrl.use_in;
	assign addr_in    = ctrl.operand[$clog2(NUIOIN)-1:0];

	decode_fl u_decode (.clk(clk), .arst_n(arst_n), .load(load), .instr(instr), .ctrl(ctrl));

	execute_fl u_execute (.alu_op(ctrl.alu_op), .acc(acc), .opnd(mem_rdata), .res(alu_res));

	result_fl u_result (
		.clk(clk), .arst_n(arst_n), .commit(commit), .ctrl(ctrl),
		.alu_res(alu_res), .io_in(io_in), .pc(pc),
		.acc(acc), .pc_next(pc_next),
		.mem_wr(mem_wr), .mem_addr_w(mem_addr_w),
		.io_out(io_out), .addr_out(addr_out), .out_en(out_en)
	);

endmodule

// File: verilog/proc_fl.sv
`timescale 1ns/1ps

module proc_fl import fl_pkg::*, isa_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  fl_word_t io_in,
	output fl_word_t io_out,
	output logic     addr_in,
	output logic     addr_out,
	output logic     req_in,
	output logic     out_en
);

	// Core to memories
	instr_t   instr;
	operand_t instr_addr;
	logic     mem_wr;
	operand_t mem_addr_w, mem_addr_r;
	fl_word_t mem_wdata, mem_rdata;

	core_fl u_core (
		.clk(clk), .arst_n(arst_n),
		.instr(instr), .instr_addr(instr_addr),
		.mem_wr(mem_wr), .mem_addr_w(mem_addr_w), .mem_addr_r(mem_addr_r),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
		.io_in(io_in), .addr_in(addr_in), .req_in(req_in),
		.io_out(io_out), .addr_out(addr_out), .out_en(out_en)
	);

	// Program ROM
	mem_instr u_mem_instr (.clk(clk), .instr_addr(instr_addr), .instr(instr));

	// Variables
	mem_data u_mem_data (
		.clk(clk), .mem_wr(mem_wr),
		.mem_addr_w(mem_addr_w), .mem_addr_r(mem_addr_r),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
	);

endmodule

// File: testbench/proc_fl_chk.sv
`timescale 1ns/1ps

module proc_fl_chk (
	input logic clk,
	input logic arst_n,
	input logic req_in,
	input logic out_en
);

	int         fails = 0;  // Failed assertion count
	logic [1:0] phase;      // Instruction rhythm, 2 is EXEC

	// Three cycles per instruction from the release of reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			phase <= 2'd0;
		else if (phase == 2'd2)
			phase <= 2'd0;
		else
			phase <= phase + 2'd1;
	end

	// ----------------------------------------
	// Output strobe timing
	// ----------------------------------------

	a_out_single: assert property (@(posedge clk) disable iff (!arst_n) out_en |=> !out_en)
		else begin
			$error("out_en stayed high for two cycles");
			fails++;
		end

	// Next pulse no sooner than one instruction later
	a_out_gap: assert property (@(posedge clk) disable iff (!arst_n)
		out_en |=> !out_en ##1 !out_en)
		else begin
			$error("out_en pulses closer than three cycles");
			fails++;
		end

	// Input request only while executing
	a_req_exec: assert property (@(posedge clk) disable iff (!arst_n) req_in |-> phase == 2'd2)
		else begin
			$error("req_in high outside EXEC");
			fails++;
		end

endmodule

// File: testbench/tb_proc_fl.sv
`timescale 1ns/1ps

module tb_proc_fl import fl_pkg::*; ();

	localparam int          TIMEOUT = 100;       // Cycles allowed per output
	localparam logic [31:0] SEED    = 32'h28bf;
	localparam int          NRAND   = 20;        // Random pairs

	logic        clk;
	logic        arst_n;
	fl_word_t    io_in, io_out;
	logic        addr_in, addr_out, req_in, out_en;
	fl_word_t    a_val, b_val;  // Input ports 0 and 1
	int          in_reads;      // req_in cycles since the pair was set
	logic [31:0] rng;           // xorshift state

	proc_fl u_dut (
		.clk(clk), .arst_n(arst_n), .io_in(io_in), .io_out(io_out),
		.addr_in(addr_in), .addr_out(addr_out), .req_in(req_in), .out_en(out_en)
	);

	bind core_fl proc_fl_chk u_chk (
		.clk(clk), .arst_n(arst_n), .req_in(req_in), .out_en(out_en)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;  // 100 MHz
	end

	// Port model follows addr_in at once
	always_comb begin
		if (addr_in)
			io_in = b_val;
		else
			io_in = a_val;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	// ----------------------------------------
	// Reference model of the number format
	// ----------------------------------------

	function automatic fl_word_t word_of(input logic s, input int e, input int m);
		fl_word_t w;
		w.sign = s;
		w.expo = fl_expo_t'(e);
		w.mant = fl_mant_t'(m);
		return w;
	endfunction

	function automatic fl_word_t clear_zero(input fl_word_t w);
		if (w.mant == '0)
			return FL_ZERO;  // Single zero form
		return w;
	endfunction

	function automatic fl_word_t sum_of(input fl_word_t x, input fl_word_t y);
		int       mx, my, mag, e;
		logic     sg;
		fl_word_t r;
		mx = int'(x.mant);
		my = int'(y.mant);
		if (x.expo >= y.expo) begin  // Smaller exponent side loses low bits
			e  = int'(x.expo);
			my = my >> (int'(x.expo) - int'(y.expo));
		end else begin
			e  = int'(y.expo);
			mx = mx >> (int'(y.expo) - int'(x.expo));
		end
		if (x.sign == y.sign) begin
			mag = mx + my;
			sg  = x.sign;
		end else if (mx >= my) begin
			mag = mx - my;
			sg  = x.sign;
		end else begin
			mag = my - mx;
			sg  = y.sign;
		end
		if (mag > 65535) begin  // Carry shifts one step right
			mag = mag >> 1;
			e   = e + 1;
		end
		r = word_of(sg, e, mag);
		return clear_zero(r);
	endfunction

	function automatic fl_word_t product_of(input fl_word_t x, input fl_word_t y);
		longint p;
		int     e;
		p = longint'(x.mant) * longint'(y.mant);
		e = int'(x.expo) + int'(y.expo);
		while (p > 65535) begin  // Fit the mantissa
			p = p >> 1;
			e++;
		end
		return clear_zero(word_of(x.sign ^ y.sign, e, int'(p)));
	endfunction

	// Exact value since a 16 bit mantissa and a small exponent fit a real
	function automatic real value_of(input fl_word_t w);
		real v;
		int  e;
		v = real'(int'(w.mant));
		for (e = int'(w.expo); e > 0; e--)
			v = v * 2.0;
		for (e = int'(w.expo); e < 0; e++)
			v = v / 2.0;
		return w.sign ? -v : v;
	endfunction

	function automatic fl_word_t greater_flag(input fl_word_t x, input fl_word_t y);
		return (value_of(x) > value_of(y)) ? FL_ONE : FL_ZERO;
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic fl_word_t random_word();
		rng = xorshift(rng);
		return word_of(rng[31], int'(rng[19:16]) - 8, int'(rng[15:0]));  // Exponent -8 to 7
	endfunction

	// ----------------------------------------
	// Stimulus and checks
	// ----------------------------------------

	task automatic wait_output(output fl_word_t val, output logic port);
		int n;
		n = 0;
		do begin
			@(negedge clk);  // Outputs settled
			n++;
			if (req_in)
				in_reads++;
		end while (!out_en && n < TIMEOUT);
		assert (out_en)
			else stop_run($sformatf("No output appeared within %0d cycles, time %0t",
				TIMEOUT, $time));
		val  = io_out;
		port = addr_out;
	endtask

	// One pass of the program gives four outputs
	task automatic run_pair(input fl_word_t a, input fl_word_t b);
		fl_word_t want [4];
		fl_word_t lod_a, t, got;
		logic     port;
		lod_a   = clear_zero(a);         // LOD goes through the ALU
		want[0] = sum_of(lod_a, b);
		want[1] = product_of(lod_a, b);
		t       = clear_zero(b);
		t.sign  = ~t.sign;
		t       = sum_of(clear_zero(t), a);
		t.sign  = 1'b0;
		want[2] = clear_zero(t);         // |a - b|
		want[3] = greater_flag(lod_a, b);
		@(posedge clk);
		a_val    <= a;
		b_val    <= b;
		in_reads = 0;
		for (int k = 0; k < 4; k++) begin
			wait_output(got, port);
			if (k == 0) begin
				assert (in_reads == 2)
					else stop_run($sformatf("ERR %0t: %0d input reads before first output",
						$time, in_reads));
			end
			assert (port == k[0])
				else stop_run($sformatf("ERR %0t: output %0d on port %0d", $time, k, port));
			assert (got == want[k])
				else stop_run($sformatf("ERR %0t: pair %h %h output %0d is %h, expected %h",
					$time, a, b, k, got, want[k]));
		end
	endtask

	task automatic check_reset();
		@(negedge clk);
		assert (!out_en && !req_in)
			else stop_run($sformatf("ERR %0t: out_en or req_in high in reset", $time));
		@(posedge clk);  // Second rising edge in reset
		arst_n <= 1'b1;
		@(negedge clk);
		assert (!out_en && !req_in)
			else stop_run($sformatf("ERR %0t: out_en or req_in high after reset", $time));
		run_pair(word_of(0, 0, 2), word_of(0, 0, 3));
	endtask

	task automatic integer_pairs();
		run_pair(word_of(0, 0, 3), word_of(0, 0, 5));
		run_pair(word_of(0, 0, 200), word_of(0, 0, 100));
		run_pair(word_of(0, 0, 255), word_of(0, 0, 255));  // Largest exact product
	endtask

	task automatic sign_pairs();
		run_pair(word_of(1, 0, 7), word_of(0, 0, 12));
		run_pair(word_of(0, 0, 9), word_of(1, 0, 9));      // Sum cancels
		run_pair(word_of(1, 0, 40), word_of(0, 0, 40));
		run_pair(word_of(1, 0, 30), word_of(1, 0, 20));
	endtask

	task automatic exponent_pairs();
		run_pair(word_of(0, 3, 5), word_of(0, 0, 7));      // b truncated away
		run_pair(word_of(0, -2, 13), word_of(0, 1, 3));
		run_pair(word_of(0, 2, 40000), word_of(1, -1, 3000));
		run_pair(word_of(0, -4, 65535), word_of(0, 5, 2));
	endtask

	task automatic compare_pairs();
		run_pair(word_of(0, 0, 10), word_of(0, 0, 3));
		run_pair(word_of(0, 0, 3), word_of(0, 0, 10));
		run_pair(word_of(0, 0, 5), word_of(0, 0, 5));
		run_pair(word_of(1, 0, 3), word_of(1, 0, 10));
		run_pair(word_of(0, 4, 1), word_of(0, 0, 15));
		run_pair(word_of(0, 1, 8), word_of(0, 2, 4));      // Same value in another form
	endtask

	task automatic random_pairs();
		fl_word_t a, b;
		repeat (NRAND) begin
			a = random_word();
			b = random_word();
			run_pair(a, b);
		end
	endtask

	initial begin
		arst_n   = 1'b0;
		a_val    = FL_ZERO;
		b_val    = FL_ZERO;
		in_reads = 0;
		rng      = SEED;
		check_reset();
		integer_pairs();
		sign_pairs();
		exponent_pairs();
		compare_pairs();
		random_pairs();
		if (u_dut.u_core.u_chk.fails == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	end

endmodule

// File: verilog/inst.hex
// Word = opcode[11:6] and operand[5:0], three hex digits per instruction
// Data address 0 holds a, address 1 holds b
0c0 // IN 0
080 // STO a
0c1 // IN 1
081 // STO b
040 // LOD a
141 // ADD b
100 // OUT 0, a + b
040 // LOD a
181 // MLT b
101 // OUT 1, a * b
041 // LOD b
1c0 // NEG
140 // ADD a
200 // ABS
100 // OUT 0, |a - b|
040 // LOD a
241 // GRE b
101 // OUT 1, a > b
2c0 // JMP 0

// File: tb.f
verilog/fl_pkg.sv
verilog/isa_pkg.sv
verilog/mem_instr.sv
verilog/mem_data.sv
verilog/decode_fl.sv
verilog/execute_fl.sv
verilog/result_fl.sv
verilog/core_fl.sv
verilog/proc_fl.sv
testbench/proc_fl_chk.sv
testbench/tb_proc_fl.sv
